//--- logic/panel_params.svh
`ifndef PANEL_PARAMS_SVH
`define PANEL_PARAMS_SVH

// **********************************************************************
// Animation timing
// **********************************************************************

`define PANEL_STEP_CYCLES 10000000  // clk2 cycles per step on the board
`define RUN_STEPS         10        // Positions of the single running LED
`define DEMO_LED_STEPS    21        // Patterns in the demo LED show
`define DEMO_WORD_STEPS   7         // Steps each demo word stays up

// **********************************************************************
// Segment codes, active low, bit 6 is segment g and bit 0 is segment a
// **********************************************************************

`define SEG_BLANK 7'b1111111

// First word "JUSt"
`define SEG_WORD0_D6 7'b1100001  // J
`define SEG_WORD0_D5 7'b1000001  // U
`define SEG_WORD0_D4 7'b0010010  // S
`define SEG_WORD0_D3 7'b0000111  // t

// Second word "CPU"
`define SEG_WORD1_D6 7'b1000110  // C
`define SEG_WORD1_D5 7'b0001100  // P
`define SEG_WORD1_D4 7'b1000001  // U
`define SEG_WORD1_D3 7'b1111111  // Blank

// Third word "bro"
`define SEG_WORD2_D6 7'b0000011  // b
`define SEG_WORD2_D5 7'b0101111  // r
`define SEG_WORD2_D4 7'b0100011  // o
`define SEG_WORD2_D3 7'b1111111  // Blank

// Label of the cycle count view
`define SEG_LBL_N 7'b0101011     // n, shown on digit_5
`define SEG_LBL_C 7'b1000110     // C, shown on digit_6

`endif

//--- logic/panel_pkg.sv
package panel_pkg;

  // **********************************************************************
  // Vector types of the front panel
  // **********************************************************************

  typedef logic [6:0]  seg_t;      // Active low, bit 6 is g, bit 0 is a
  typedef logic [31:0] word_t;     // Register value or cycle count
  typedef logic [3:0]  nibble_t;   // One hex digit
  typedef logic [4:0]  reg_idx_t;  // Register index, 0 to 31
  typedef logic [9:0]  led_t;      // Bit 9 is the leftmost LED

  // **********************************************************************
  // Display mode
  // **********************************************************************

  // OFF while reset is low, VIEW with en high, DEMO with en low
  typedef enum logic [1:0] {
    MODE_OFF,
    MODE_VIEW,
    MODE_DEMO
  } mode_t;

endpackage

//--- logic/hex_to_seg.sv
`include "panel_params.svh"

module hex_to_seg (
  input  panel_pkg::nibble_t value,
  output panel_pkg::seg_t    seg
);

  always_comb begin
    seg = `SEG_BLANK;
    case (value)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0011000;
      4'hA: seg = 7'b0001000;
      4'hB: seg = 7'b0000011;  // Lower case b
      4'hC: seg = 7'b1000110;
      4'hD: seg = 7'b0100001;  // Lower case d
      4'hE: seg = 7'b0000110;
      4'hF: seg = 7'b0001110;
      default: seg = `SEG_BLANK;
    endcase
  end

endmodule

//--- logic/view_select.sv
`include "panel_params.svh"

module view_select (
  input  logic                     clk2,
  input  logic                     reset,
  input  logic                     num_of_cycles,
  input  logic                     selector,
  input  panel_pkg::reg_idx_t      mux32,
  input  panel_pkg::word_t         reg_data,
  input  panel_pkg::word_t         cycles_count,
  output panel_pkg::nibble_t [3:0] shown_half,
  output panel_pkg::seg_t          label_lo,
  output panel_pkg::seg_t          label_hi
);

  panel_pkg::word_t    word_sel;
  panel_pkg::reg_idx_t idx_rem;
  panel_pkg::nibble_t  tens;
  panel_pkg::nibble_t  units;
  panel_pkg::seg_t     tens_seg;
  panel_pkg::seg_t     units_seg;

  assign word_sel = num_of_cycles ? cycles_count : reg_data;

  // **********************************************************************
  // Decimal split of the register index
  // **********************************************************************

  always_comb begin
    if (mux32 >= 5'd30) begin
      tens    = 4'd3;
      idx_rem = mux32 - 5'd30;
    end else if (mux32 >= 5'd20) begin
      tens    = 4'd2;
      idx_rem = mux32 - 5'd20;
    end else if (mux32 >= 5'd10) begin
      tens    = 4'd1;
      idx_rem = mux32 - 5'd10;
    end else begin
      tens    = 4'd0;
      idx_rem = mux32;
    end
    units = idx_rem[3:0];  // Remainder is below ten
  end

  hex_to_seg units_dec_inst (
    .value (units),
    .seg   (units_seg)
  );

  hex_to_seg tens_dec_inst (
    .value (tens),
    .seg   (tens_seg)
  );

  // **********************************************************************
  // First pipeline stage of the view
  // **********************************************************************

  always_ff @(posedge clk2) begin
    shown_half <= selector ? word_sel[31:16] : word_sel[15:0];  // High or low half
  end

  always_ff @(posedge clk2) begin
    if (!reset) begin
      label_lo <= `SEG_BLANK;
      label_hi <= `SEG_BLANK;
    end else if (num_of_cycles) begin
      label_lo <= `SEG_LBL_N;
      label_hi <= `SEG_LBL_C;
    end else begin
      label_lo <= units_seg;
      label_hi <= tens_seg;
    end
  end

  // Tens and units rebuild the index, tens stay in 0..3
  assert property (@(posedge clk2)
    (tens <= 4'd3) && (units <= 4'd9) &&
    (int'(tens) * 10 + int'(units) == int'(mux32)));

endmodule

//--- logic/led_animator.sv
`include "panel_params.svh"

module led_animator #(
  parameter int STEP_CYCLES = `PANEL_STEP_CYCLES
) (
  input  logic             clk2,
  input  panel_pkg::mode_t mode,
  output panel_pkg::led_t  leds
);

  localparam int CNT_W  = $clog2(STEP_CYCLES + 1);
  localparam int STEP_W = $clog2(`DEMO_LED_STEPS);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STEP_CYCLES - 1);

  panel_pkg::mode_t  mode_prev;
  logic [CNT_W-1:0]  cnt_q;
  logic [CNT_W-1:0]  cnt_d;
  logic [STEP_W-1:0] step_q;
  logic [STEP_W-1:0] step_d;
  logic [STEP_W-1:0] step_last;

  // **********************************************************************
  // Demo show, one pattern per step
  // **********************************************************************

  function automatic panel_pkg::led_t demo_pattern(input logic [STEP_W-1:0] idx);
    panel_pkg::led_t pat;
    case (idx)
      5'd0:    pat = 10'b1010101010;  // Alternate blink
      5'd1:    pat = 10'b0101010101;
      5'd2:    pat = 10'b1010101010;
      5'd3:    pat = 10'b0101010101;
      5'd4:    pat = 10'b1010101010;
      5'd5:    pat = 10'b0000000000;  // Full flash
      5'd6:    pat = 10'b1111111111;
      5'd7:    pat = 10'b0000000000;
      5'd8:    pat = 10'b1111111111;
      5'd9:    pat = 10'b1000000001;  // Close in from both ends
      5'd10:   pat = 10'b0100000010;
      5'd11:   pat = 10'b0010000100;
      5'd12:   pat = 10'b0001001000;
      5'd13:   pat = 10'b0000110000;
      5'd14:   pat = 10'b1000110001;  // Stack up in the middle
      5'd15:   pat = 10'b0100110010;
      5'd16:   pat = 10'b0010110100;
      5'd17:   pat = 10'b0001111000;
      5'd18:   pat = 10'b1001111001;
      5'd19:   pat = 10'b0101111010;
      5'd20:   pat = 10'b0011111100;
      default: pat = '0;
    endcase
    return pat;
  endfunction

  // **********************************************************************
  // Step counter, restarted on every change of mode
  // **********************************************************************

  always_comb begin
    if (mode == panel_pkg::MODE_VIEW) begin
      step_last = STEP_W'(`RUN_STEPS - 1);
    end else begin
      step_last = STEP_W'(`DEMO_LED_STEPS - 1);
    end
    cnt_d  = cnt_q + 1'b1;
    step_d = step_q;
    if (mode == panel_pkg::MODE_OFF || mode != mode_prev) begin
      cnt_d  = '0;
      step_d = '0;
    end else if (cnt_q == CNT_LAST) begin
      cnt_d  = '0;
      step_d = (step_q == step_last) ? '0 : step_q + 1'b1;  // Wrap at the mode's limit
    end
  end

  always_ff @(posedge clk2) begin
    mode_prev <= mode;
    cnt_q     <= cnt_d;
    step_q    <= step_d;
    case (mode)
      panel_pkg::MODE_VIEW: leds <= 10'b1000000000 >> step_d;  // One LED running down
      panel_pkg::MODE_DEMO: leds <= demo_pattern(step_d);
      default:              leds <= '0;
    endcase
  end

  // Step counted in a mode stays inside that mode's table
  assert property (@(posedge clk2)
    (mode_prev == panel_pkg::MODE_VIEW) |-> (step_q < STEP_W'(`RUN_STEPS)));

  assert property (@(posedge clk2)
    (mode_prev == panel_pkg::MODE_DEMO) |-> (step_q < STEP_W'(`DEMO_LED_STEPS)));

endmodule

//--- logic/banner_sequencer.sv
`include "panel_params.svh"

module banner_sequencer #(
  parameter int STEP_CYCLES = `PANEL_STEP_CYCLES
) (
  input  logic             clk2,
  input  panel_pkg::mode_t mode,
  output panel_pkg::seg_t  word_d3,
  output panel_pkg::seg_t  word_d4,
  output panel_pkg::seg_t  word_d5,
  output panel_pkg::seg_t  word_d6
);

  localparam int CNT_W = $clog2(STEP_CYCLES + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(STEP_CYCLES - 1);
  localparam logic [2:0] SUB_LAST = 3'(`DEMO_WORD_STEPS - 1);

  panel_pkg::mode_t mode_prev;
  logic [CNT_W-1:0] cnt_q;
  logic [CNT_W-1:0] cnt_d;
  logic [2:0]       sub_q;   // Step inside the current word
  logic [2:0]       sub_d;
  logic [1:0]       word_q;  // Word 0, 1 or 2
  logic [1:0]       word_d;

  always_comb begin
    cnt_d  = cnt_q + 1'b1;
    sub_d  = sub_q;
    word_d = word_q;
    if (mode != panel_pkg::MODE_DEMO || mode != mode_prev) begin
      cnt_d  = '0;
      sub_d  = '0;
      word_d = '0;
    end else if (cnt_q == CNT_LAST) begin
      cnt_d = '0;
      if (sub_q == SUB_LAST) begin
        sub_d  = '0;
        word_d = (word_q == 2'd2) ? 2'd0 : word_q + 1'b1;  // Wrap after the third word
      end else begin
        sub_d = sub_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk2) begin
    mode_prev <= mode;
    cnt_q     <= cnt_d;
    sub_q     <= sub_d;
    word_q    <= word_d;
    if (mode != panel_pkg::MODE_DEMO) begin
      word_d6 <= `SEG_BLANK;
      word_d5 <= `SEG_BLANK;
      word_d4 <= `SEG_BLANK;
      word_d3 <= `SEG_BLANK;
    end else begin
      case (word_d)
        2'd0: begin
          word_d6 <= `SEG_WORD0_D6;
          word_d5 <= `SEG_WORD0_D5;
          word_d4 <= `SEG_WORD0_D4;
          word_d3 <= `SEG_WORD0_D3;
        end
        2'd1: begin
          word_d6 <= `SEG_WORD1_D6;
          word_d5 <= `SEG_WORD1_D5;
          word_d4 <= `SEG_WORD1_D4;
          word_d3 <= `SEG_WORD1_D3;
        end
        default: begin
          word_d6 <= `SEG_WORD2_D6;
          word_d5 <= `SEG_WORD2_D5;
          word_d4 <= `SEG_WORD2_D4;
          word_d3 <= `SEG_WORD2_D3;
        end
      endcase
    end
  end

endmodule

//--- logic/panel_top.sv
`include "panel_params.svh"

module panel_top #(
  parameter int STEP_CYCLES = `PANEL_STEP_CYCLES
) (
  input  logic                clk2,
  input  logic                reset,
  input  logic                en,
  input  logic                num_of_cycles,
  input  logic                selector,
  input  panel_pkg::reg_idx_t mux32,
  input  panel_pkg::word_t    reg_data,
  input  panel_pkg::word_t    cycles_count,
  output panel_pkg::reg_idx_t reg_sel,
  output panel_pkg::seg_t     digit_1,
  output panel_pkg::seg_t     digit_2,
  output panel_pkg::seg_t     digit_3,
  output panel_pkg::seg_t     digit_4,
  output panel_pkg::seg_t     digit_5,
  output panel_pkg::seg_t     digit_6,
  output panel_pkg::led_t     leds
);

  panel_pkg::mode_t         mode;
  panel_pkg::mode_t         mode_q;      // Lines up with the view_select registers
  panel_pkg::nibble_t [3:0] shown_half;
  panel_pkg::seg_t          label_lo;
  panel_pkg::seg_t          label_hi;
  panel_pkg::seg_t          hex_seg [4];
  panel_pkg::seg_t          word_d3;
  panel_pkg::seg_t          word_d4;
  panel_pkg::seg_t          word_d5;
  panel_pkg::seg_t          word_d6;

  assign reg_sel = mux32;  // Processor answers on reg_data in the same cycle

  always_comb begin
    if (!reset) begin
      mode = panel_pkg::MODE_OFF;
    end else if (en) begin
      mode = panel_pkg::MODE_VIEW;
    end else begin
      mode = panel_pkg::MODE_DEMO;
    end
  end

  // **********************************************************************
  // Blocks
  // **********************************************************************

  view_select view_select_inst (
    .clk2          (clk2),
    .reset         (reset),
    .num_of_cycles (num_of_cycles),
    .selector      (selector),
    .mux32         (mux32),
    .reg_data      (reg_data),
    .cycles_count  (cycles_count),
    .shown_half    (shown_half),
    .label_lo      (label_lo),
    .label_hi      (label_hi)
  );

  for (genvar i = 0; i < 4; i++) begin : g_hex
    hex_to_seg hex_to_seg_inst (
      .value (shown_half[i]),
      .seg   (hex_seg[i])
    );
  end

  led_animator #(
    .STEP_CYCLES (STEP_CYCLES)
  ) led_animator_inst (
    .clk2 (clk2),
    .mode (mode),
    .leds (leds)
  );

  banner_sequencer #(
    .STEP_CYCLES (STEP_CYCLES)
  ) banner_sequencer_inst (
    .clk2    (clk2),
    .mode    (mode),
    .word_d3 (word_d3),
    .word_d4 (word_d4),
    .word_d5 (word_d5),
    .word_d6 (word_d6)
  );

  // **********************************************************************
  // Digit output registers
  // **********************************************************************

  always_ff @(posedge clk2) begin
    mode_q <= mode;
  end

  always_ff @(posedge clk2) begin
    if (!reset) begin
      digit_1 <= `SEG_BLANK;
      digit_2 <= `SEG_BLANK;
      digit_3 <= `SEG_BLANK;
      digit_4 <= `SEG_BLANK;
      digit_5 <= `SEG_BLANK;
      digit_6 <= `SEG_BLANK;
    end else begin
      case (mode_q)
        panel_pkg::MODE_VIEW: begin
          digit_1 <= hex_seg[0];  // Lowest nibble of the half
          digit_2 <= hex_seg[1];
          digit_3 <= hex_seg[2];
          digit_4 <= hex_seg[3];
          digit_5 <= label_lo;
          digit_6 <= label_hi;
        end
        panel_pkg::MODE_DEMO: begin
          digit_1 <= `SEG_BLANK;
          digit_2 <= `SEG_BLANK;
          digit_3 <= word_d3;
          digit_4 <= word_d4;
          digit_5 <= word_d5;
          digit_6 <= word_d6;
        end
        default: begin
          digit_1 <= `SEG_BLANK;
          digit_2 <= `SEG_BLANK;
          digit_3 <= `SEG_BLANK;
          digit_4 <= `SEG_BLANK;
          digit_5 <= `SEG_BLANK;
          digit_6 <= `SEG_BLANK;
        end
      endcase
    end
  end

endmodule

//--- test/tb_panel_top.sv
`include "panel_params.svh"

module tb_panel_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int step_cycles  = 4;
  localparam int chase_cycles = 2 * `RUN_STEPS * step_cycles;       // Two full chase rounds
  localparam int demo_cycles  = 2 * `DEMO_LED_STEPS * step_cycles;  // Two full shows
  localparam int watchdog_cycles = 4 * (chase_cycles + demo_cycles) + 1000;

  // **********************************************************************
  // Expected patterns
  // **********************************************************************

  localparam panel_pkg::seg_t hex_table [16] = '{
    7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
    7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
    7'b0000000, 7'b0011000, 7'b0001000, 7'b0000011,
    7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
  };

  localparam panel_pkg::led_t run_table [10] = '{
    10'b1000000000, 10'b0100000000, 10'b0010000000, 10'b0001000000, 10'b0000100000,
    10'b0000010000, 10'b0000001000, 10'b0000000100, 10'b0000000010, 10'b0000000001
  };

  localparam panel_pkg::led_t demo_table [21] = '{
    10'b1010101010, 10'b0101010101, 10'b1010101010, 10'b0101010101,  // Alternate blink
    10'b1010101010, 10'b0000000000, 10'b1111111111, 10'b0000000000,
    10'b1111111111, 10'b1000000001, 10'b0100000010, 10'b0010000100,  // Closing in
    10'b0001001000, 10'b0000110000, 10'b1000110001, 10'b0100110010,
    10'b0010110100, 10'b0001111000, 10'b1001111001, 10'b0101111010,
    10'b0011111100
  };

  localparam panel_pkg::seg_t word_d6_table [3] = '{`SEG_WORD0_D6, `SEG_WORD1_D6, `SEG_WORD2_D6};
  localparam panel_pkg::seg_t word_d5_table [3] = '{`SEG_WORD0_D5, `SEG_WORD1_D5, `SEG_WORD2_D5};
  localparam panel_pkg::seg_t word_d4_table [3] = '{`SEG_WORD0_D4, `SEG_WORD1_D4, `SEG_WORD2_D4};
  localparam panel_pkg::seg_t word_d3_table [3] = '{`SEG_WORD0_D3, `SEG_WORD1_D3, `SEG_WORD2_D3};

  logic                clk2;
  logic                reset;
  logic                en;
  logic                num_of_cycles;
  logic                selector;
  panel_pkg::reg_idx_t mux32;
  panel_pkg::word_t    reg_data;
  panel_pkg::word_t    cycles_count;
  panel_pkg::reg_idx_t reg_sel;
  panel_pkg::seg_t     digit_1;
  panel_pkg::seg_t     digit_2;
  panel_pkg::seg_t     digit_3;
  panel_pkg::seg_t     digit_4;
  panel_pkg::seg_t     digit_5;
  panel_pkg::seg_t     digit_6;
  panel_pkg::led_t     leds;

  panel_pkg::word_t    regs [32];  // Processor register file model
  int                  errors;
  int                  tests_run;

  assign reg_data = regs[reg_sel];  // Processor answers in the same cycle

  panel_top #(
    .STEP_CYCLES (step_cycles)
  ) panel_top_inst (
    .clk2          (clk2),
    .reset         (reset),
    .en            (en),
    .num_of_cycles (num_of_cycles),
    .selector      (selector),
    .mux32         (mux32),
    .reg_data      (reg_data),
    .cycles_count  (cycles_count),
    .reg_sel       (reg_sel),
    .digit_1       (digit_1),
    .digit_2       (digit_2),
    .digit_3       (digit_3),
    .digit_4       (digit_4),
    .digit_5       (digit_5),
    .digit_6       (digit_6),
    .leds          (leds)
  );

  initial begin
    clk2 = 1'b0;
    forever #20 clk2 = ~clk2;  // 40 ns period
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk2);
    $display("Watchdog expired after %0d cycles, the tests did not finish", watchdog_cycles);
    $display("FAIL: see errors above");
    $finish;
  end

  // **********************************************************************
  // Helpers
  // **********************************************************************

  task automatic report_mismatch(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
    errors++;
    $display("Fail %s %s: expected %0h, actual %0h", test, what, expected, actual);
  endtask

  // Digit 1 in the low seven bits, digit 6 on top
  function automatic logic [41:0] view_digits(input logic [15:0] half,
                                              input panel_pkg::seg_t lo,
                                              input panel_pkg::seg_t hi);
    return {hi, lo, hex_table[half[15:12]], hex_table[half[11:8]],
            hex_table[half[7:4]], hex_table[half[3:0]]};
  endfunction

  task automatic compare_digits(input string test, input logic [41:0] expected);
    logic [41:0] actual;
    int          d;
    actual = {digit_6, digit_5, digit_4, digit_3, digit_2, digit_1};
    for (d = 0; d < 6; d++) begin
      if (actual[d*7 +: 7] !== expected[d*7 +: 7]) begin
        report_mismatch(test, $sformatf("digit_%0d", d + 1), expected[d*7 +: 7],
                        actual[d*7 +: 7]);
      end
    end
  endtask

  // **********************************************************************
  // Tests
  // **********************************************************************

  task automatic reset_test();
    int cycle;
    tests_run++;
    for (cycle = 0; cycle < 4; cycle++) begin
      @(posedge clk2);
      @(negedge clk2);
      compare_digits("reset", {6{`SEG_BLANK}});
      if (leds !== '0) report_mismatch("reset", "leds", '0, leds);
    end
    reset = 1'b1;
    @(negedge clk2);
    compare_digits("reset_release", {6{`SEG_BLANK}});  // Digits still lag one cycle
  endtask

  task automatic register_view_test(input int idx, input logic high);
    logic [15:0] half;
    string       name;
    tests_run++;
    name = high ? "register_view_high" : "register_view_low";
    @(negedge clk2);
    en            = 1'b1;
    num_of_cycles = 1'b0;
    selector      = high;
    mux32         = 5'(idx);
    repeat (2) @(posedge clk2);  // Two stage pipeline
    @(negedge clk2);
    if (reg_sel !== 5'(idx)) report_mismatch(name, "reg_sel", idx, reg_sel);
    half = high ? regs[idx][31:16] : regs[idx][15:0];
    compare_digits(name, view_digits(half, hex_table[idx % 10], hex_table[idx / 10]));
  endtask

  task automatic cycle_view_test(input int idx, input logic high);
    logic [15:0] half;
    tests_run++;
    @(negedge clk2);
    en            = 1'b1;
    num_of_cycles = 1'b1;
    selector      = high;
    mux32         = 5'(idx);  // Ignored for the label
    cycles_count  = $urandom();
    repeat (2) @(posedge clk2);
    @(negedge clk2);
    half = high ? cycles_count[31:16] : cycles_count[15:0];
    compare_digits("cycle_view", view_digits(half, `SEG_LBL_N, `SEG_LBL_C));
  endtask

  task automatic run_chase_test();
    int cycle;
    int step;
    tests_run++;
    @(negedge clk2);
    num_of_cycles = 1'b0;
    en            = 1'b0;  // One demo cycle restarts the chase
    @(negedge clk2);
    en = 1'b1;
    for (cycle = 0; cycle < chase_cycles; cycle++) begin
      @(negedge clk2);
      step = (cycle / step_cycles) % `RUN_STEPS;
      if (leds !== run_table[step]) begin
        report_mismatch("run_chase", $sformatf("leds at step %0d", step), run_table[step], leds);
      end
    end
  endtask

  task automatic demo_test();
    int cycle;
    int step;
    int word;
    tests_run++;
    @(negedge clk2);
    en = 1'b0;
    for (cycle = 0; cycle < demo_cycles; cycle++) begin
      @(negedge clk2);
      step = (cycle / step_cycles) % `DEMO_LED_STEPS;
      if (leds !== demo_table[step]) begin
        report_mismatch("demo_leds", $sformatf("leds at step %0d", step), demo_table[step], leds);
      end
      // Digits trail the banner block by one register
      if (cycle > 0) begin
        word = ((cycle - 1) / (step_cycles * `DEMO_WORD_STEPS)) % 3;
        compare_digits("demo_words", {word_d6_table[word], word_d5_table[word],
                                      word_d4_table[word], word_d3_table[word],
                                      `SEG_BLANK, `SEG_BLANK});
      end
    end
  endtask

  // **********************************************************************
  // Main sequence
  // **********************************************************************

  initial begin
    int i;
    void'($urandom(48326));
    errors        = 0;
    tests_run     = 0;
    reset         = 1'b0;
    en            = 1'b1;
    num_of_cycles = 1'b0;
    selector      = 1'b0;
    mux32         = '0;
    for (i = 0; i < 32; i++) begin
      regs[i] = $urandom();
    end
    cycles_count = $urandom();

    reset_test();
    register_view_test(0, 1'b0);
    register_view_test(7, 1'b0);
    register_view_test(13, 1'b0);
    register_view_test(22, 1'b0);
    register_view_test(31, 1'b0);
    register_view_test(9, 1'b1);
    register_view_test(10, 1'b1);
    register_view_test(30, 1'b1);
    cycle_view_test(5, 1'b0);
    cycle_view_test(27, 1'b1);
    run_chase_test();
    demo_test();

    $display("Summary: %0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+logic
logic/panel_pkg.sv
logic/hex_to_seg.sv
logic/view_select.sv
logic/led_animator.sv
logic/banner_sequencer.sv
logic/panel_top.sv
test/tb_panel_top.sv

//--- run_sim.sh
#!/bin/sh
# Build the front panel testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timescale 1ns/1ps -Wno-fatal -f vlog.f --top-module tb_panel_top \
  -Mdir obj_dir -o tb_panel_top || { echo "Build failed"; exit 1; }
./obj_dir/tb_panel_top | tee sim.log
grep -qx "PASS: all tests" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
